// ==== vlog.f ====
+incdir+design
design/mem_ctrl_pkg.sv
design/mem_req_capture.sv
design/mem_access_seq.sv
design/mem_load_assemble.sv
design/mem_ctrl_top.sv
bench/tb_cache_model.sv
bench/tb_mem_ctrl.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_mem_ctrl
LINT_TOP  ?= mem_ctrl_top
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
PASS_MSG  ?= *** PASSED ***
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
LINTFLAGS ?= --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qF -- '$(PASS_MSG)'

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(LINT_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

// ==== bench/tb_mem_ctrl.sv ====
/*
 * Load/store controller testbench.
 * Applies a table of scalar and vector requests through a behavioral
 * cache and checks status sequence, load results, access counts and
 * cache contents against a reference byte memory.
 */
`timescale 1ns/1ps
`include "mem_ctrl_macros.svh"

module tb_mem_ctrl;

    localparam int MEM_BYTES = 4096;
    localparam int AW        = $clog2(MEM_BYTES);
    localparam int NROWS     = 23;
    localparam int TIMEOUT   = 200;

    localparam mem_ctrl_pkg::mem_op_e    LD = mem_ctrl_pkg::MEM_LOAD;
    localparam mem_ctrl_pkg::mem_op_e    ST = mem_ctrl_pkg::MEM_STORE;
    localparam mem_ctrl_pkg::data_type_e B1 = mem_ctrl_pkg::DT_ONE_BYTE;
    localparam mem_ctrl_pkg::data_type_e B2 = mem_ctrl_pkg::DT_TWO_BYTE;
    localparam mem_ctrl_pkg::data_type_e B4 = mem_ctrl_pkg::DT_FOUR_BYTE;
    localparam mem_ctrl_pkg::data_type_e B8 = mem_ctrl_pkg::DT_EIGHT_BYTE;

    typedef struct packed {
        mem_ctrl_pkg::mem_op_e      op;
        logic                       is_vec;
        mem_ctrl_pkg::data_type_e   dt;
        logic [`MC_ADDR_W-1:0]      addr;
        logic [`MC_LEN_W-1:0]       len;
        logic                       vm;
        logic [`MC_MAX_ELEMS-1:0]   mask;
        logic [`MC_SCALAR_W-1:0]    sdata;  // vector data is derived from it
    } row_t;

    logic                           clk;
    logic                           arst_n;
    logic                           mem_access_enabled;
    mem_ctrl_pkg::mem_op_e          op;
    logic                           is_vector;
    mem_ctrl_pkg::data_type_e       data_type;
    logic [`MC_ADDR_W-1:0]          addr;
    logic [`MC_LEN_W-1:0]           length;
    logic                           vm;
    logic [`MC_MAX_ELEMS-1:0]       mask;
    logic [`MC_SCALAR_W-1:0]        scalar_wdata;
    logic [`MC_VEC_W-1:0]           vector_wdata;
    mem_ctrl_pkg::mem_status_e      mem_status;
    logic [`MC_SCALAR_W-1:0]        scalar_rdata;
    logic [`MC_VEC_W-1:0]           vector_rdata;
    mem_ctrl_pkg::cache_req_t       cache_req;
    mem_ctrl_pkg::cache_status_e    cache_status;
    logic [`MC_WORD_W-1:0]          cache_rdata;
    int                             access_count;
    logic                           proto_err;

    row_t                           rows [NROWS];
    logic [7:0]                     ref_mem [MEM_BYTES];
    logic [`MC_SCALAR_W-1:0]        exp_scalar;
    logic [`MC_VEC_W-1:0]           exp_vec;
    int                             exp_count;

    mem_ctrl_top DUT (.*);

    tb_cache_model #(.MEM_BYTES(MEM_BYTES)) cache_model (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [7:0] init_byte(input int a);
        return 8'(a * 7) ^ 8'(a >> 5);
    endfunction

    function automatic int elem_bytes(input mem_ctrl_pkg::data_type_e dt);
        return (dt == B1) ? 1 : (dt == B2) ? 2 : 4;
    endfunction

    function automatic logic [AW-1:0] byte_index(input logic [`MC_ADDR_W-1:0] base,
                                                 input int off);
        return AW'(int'(base) + off);
    endfunction

    // distinct byte everywhere in the vector
    function automatic logic [`MC_VEC_W-1:0] vector_pattern(input logic [63:0] s);
        logic [`MC_VEC_W-1:0] v;
        for (int b = 0; b < `MC_VEC_W / 8; b++) begin
            v[8*b +: 8] = s[8*(b % 8) +: 8] ^ 8'(b * 29);
        end
        return v;
    endfunction

    task automatic report_error(input string msg);
        $display("CHECK FAILED at %0t: %s", $time, msg);
        $display("*** FAILED ***");
        $fatal(1);
    endtask

    task automatic timed_out(input string msg);
        $display("Timed out at %0t while waiting for %s", $time, msg);
        $display("*** FAILED ***");
        $fatal(1);
    endtask

    // updates ref_mem and sets the expected results for one request
    task automatic model_request(input row_t rw, input logic [`MC_VEC_W-1:0] vdata);
        int                 nbytes;
        int                 sz;
        int                 off;
        logic [63:0]        word;
        exp_count = 0;
        exp_vec   = '0;
        if (!rw.is_vec) begin
            nbytes    = (rw.dt == B8) ? 8 : 4;
            exp_count = nbytes / 4;
            word      = '0;
            for (int k = 0; k < nbytes; k++) begin
                if (rw.op == ST) ref_mem[byte_index(rw.addr, k)] = rw.sdata[8*k +: 8];
                word[8*k +: 8] = ref_mem[byte_index(rw.addr, k)];
            end
            if (rw.op == LD) begin
                exp_scalar = (nbytes == 4) ? {{32{word[31]}}, word[31:0]} : word;
            end
        end else begin
            sz = elem_bytes(rw.dt);
            for (int i = 0; i < int'(rw.len); i++) begin
                if (rw.vm || rw.mask[i]) begin
                    exp_count++;
                    for (int k = 0; k < sz; k++) begin
                        off = i * sz + k;
                        if (rw.op == ST) ref_mem[byte_index(rw.addr, off)] = vdata[8*off +: 8];
                        exp_vec[8*off +: 8] = ref_mem[byte_index(rw.addr, off)];
                    end
                end
            end
        end
    endtask

    task automatic run_row(input int r);
        row_t   rw;
        int     count_before;
        int     cycles;
        rw = rows[r];
        @(negedge clk);
        op                 = rw.op;
        is_vector          = rw.is_vec;
        data_type          = rw.dt;
        addr               = rw.addr;
        length             = rw.len;
        vm                 = rw.vm;
        mask               = rw.mask;
        scalar_wdata       = rw.sdata;
        vector_wdata       = vector_pattern(rw.sdata);
        mem_access_enabled = 1'b1;
        count_before       = access_count;
        model_request(rw, vector_pattern(rw.sdata));
        @(negedge clk);
        mem_access_enabled = 1'b0;
        assert (mem_status == mem_ctrl_pkg::MEM_WORKING)
            else report_error($sformatf("row %0d status %s after take", r, mem_status.name()));
        cycles = 1;
        while (mem_status != mem_ctrl_pkg::MEM_FINISHED) begin
            assert (mem_status == mem_ctrl_pkg::MEM_WORKING ||
                    mem_status == mem_ctrl_pkg::MEM_STALL)
                else report_error($sformatf("row %0d status %s before finished",
                                            r, mem_status.name()));
            if (cycles >= TIMEOUT) timed_out($sformatf("finished on row %0d", r));
            @(negedge clk);
            cycles++;
        end
        assert (access_count - count_before == exp_count)
            else report_error($sformatf("row %0d made %0d cache accesses, expected %0d",
                                        r, access_count - count_before, exp_count));
        if (rw.op == LD && !rw.is_vec) begin
            assert (scalar_rdata == exp_scalar)
                else report_error($sformatf("row %0d scalar_rdata %h, expected %h",
                                            r, scalar_rdata, exp_scalar));
        end
        if (rw.op == LD && rw.is_vec) begin
            assert (vector_rdata == exp_vec)
                else report_error($sformatf("row %0d vector_rdata %h, expected %h",
                                            r, vector_rdata, exp_vec));
        end
        if (exp_count == 0) begin
            assert (cycles <= `MC_MAX_ELEMS + 3)
                else report_error($sformatf("row %0d took %0d cycles with no access", r, cycles));
        end
        assert (!proto_err) else report_error($sformatf("row %0d broke the cache handshake", r));
        for (int a = 0; a < MEM_BYTES; a++) begin
            assert (cache_model.mem[a] == ref_mem[a])
                else report_error($sformatf("row %0d cache byte %h is %h, expected %h",
                                            r, a, cache_model.mem[a], ref_mem[a]));
        end
        @(negedge clk);
        assert (mem_status == mem_ctrl_pkg::MEM_RESTING && cache_req.cmd == mem_ctrl_pkg::CACHE_NOP)
            else report_error($sformatf("row %0d not resting after finished", r));
    endtask

    initial begin
        arst_n             = 1'b0;
        mem_access_enabled = 1'b0;
        op                 = mem_ctrl_pkg::MEM_NOP;
        is_vector          = 1'b0;
        data_type          = B1;
        addr               = '0;
        length             = '0;
        vm                 = 1'b0;
        mask               = '0;
        scalar_wdata       = '0;
        vector_wdata       = '0;
        exp_scalar         = '0;
        for (int a = 0; a < MEM_BYTES; a++) begin
            ref_mem[a] = init_byte(a);
        end
        // op, vec, type, addr, len, vm, mask, data
        rows[0]  = '{ST, 1'b0, B4, 20'h100, 4'd0, 1'b0, 8'h00, 64'h0000_0000_8123_4567};
        rows[1]  = '{LD, 1'b0, B4, 20'h100, 4'd0, 1'b0, 8'h00, 64'h0};
        rows[2]  = '{ST, 1'b0, B4, 20'h104, 4'd0, 1'b0, 8'h00, 64'h0000_0000_1234_5678};
        rows[3]  = '{LD, 1'b0, B4, 20'h104, 4'd0, 1'b0, 8'h00, 64'h0};
        rows[4]  = '{ST, 1'b0, B8, 20'h200, 4'd0, 1'b0, 8'h00, 64'hfedc_ba98_7654_3210};
        rows[5]  = '{LD, 1'b0, B8, 20'h200, 4'd0, 1'b0, 8'h00, 64'h0};
        rows[6]  = '{LD, 1'b0, B4, 20'h204, 4'd0, 1'b0, 8'h00, 64'h0};  // high word alone
        rows[7]  = '{ST, 1'b1, B1, 20'h300, 4'd8, 1'b1, 8'h00, 64'h0807_0605_0403_0201};
        rows[8]  = '{LD, 1'b1, B1, 20'h300, 4'd8, 1'b1, 8'h00, 64'h0};
        rows[9]  = '{LD, 1'b1, B1, 20'h300, 4'd3, 1'b1, 8'h00, 64'h0};
        rows[10] = '{ST, 1'b1, B2, 20'h400, 4'd5, 1'b0, 8'hff, 64'h1111_2222_3333_4444};
        rows[11] = '{LD, 1'b1, B2, 20'h400, 4'd8, 1'b1, 8'h00, 64'h0};
        rows[12] = '{ST, 1'b1, B4, 20'h500, 4'd8, 1'b1, 8'h00, 64'hdead_beef_cafe_f00d};
        rows[13] = '{LD, 1'b1, B4, 20'h500, 4'd8, 1'b1, 8'h00, 64'h0};
        rows[14] = '{ST, 1'b1, B4, 20'h600, 4'd6, 1'b0, 8'h2d, 64'h0123_4567_89ab_cdef};
        rows[15] = '{LD, 1'b1, B4, 20'h600, 4'd8, 1'b1, 8'h00, 64'h0};
        rows[16] = '{LD, 1'b1, B2, 20'h400, 4'd7, 1'b0, 8'h56, 64'h0};
        rows[17] = '{ST, 1'b1, B1, 20'h700, 4'd4, 1'b1, 8'h00, 64'h5a5a_a5a5_3c3c_c3c3};
        rows[18] = '{LD, 1'b1, B1, 20'h700, 4'd8, 1'b1, 8'h00, 64'h0};
        rows[19] = '{ST, 1'b1, B2, 20'h800, 4'd8, 1'b0, 8'h00, 64'h7777_8888_9999_aaaa};
        rows[20] = '{LD, 1'b1, B4, 20'h600, 4'd0, 1'b1, 8'h00, 64'h0};
        rows[21] = '{LD, 1'b1, B1, 20'h300, 4'd1, 1'b1, 8'h00, 64'h0};
        rows[22] = '{LD, 1'b1, B1, 20'h700, 4'd8, 1'b0, 8'h00, 64'h0};
        repeat (16) @(negedge clk);
        arst_n = 1'b1;
        @(negedge clk);
        assert (mem_status == mem_ctrl_pkg::MEM_RESTING && cache_req.cmd == mem_ctrl_pkg::CACHE_NOP)
            else report_error("controller not resting after reset");
        assert (scalar_rdata == '0 && vector_rdata == '0)
            else report_error("load results not zero after reset");
        for (int r = 0; r < NROWS; r++) begin
            run_row(r);
        end
        $display("*** PASSED ***");
        $finish;
    end

endmodule

// ==== bench/tb_cache_model.sv ====
/*
 * Behavioral data cache for the load/store controller testbench.
 * Byte-addressed memory behind a level handshake. It takes a held command
 * while resting, stays busy for a random number of cycles, then reports
 * finished for one cycle. Counts accesses and flags handshake misuse.
 */
`timescale 1ns/1ps
`include "mem_ctrl_macros.svh"

module tb_cache_model #(
    parameter int MEM_BYTES = 4096
) (
    input  logic                            clk,
    input  logic                            arst_n,
    input  mem_ctrl_pkg::cache_req_t        cache_req,
    output mem_ctrl_pkg::cache_status_e     cache_status,
    output logic [`MC_WORD_W-1:0]           cache_rdata,
    output int                              access_count,
    output logic                            proto_err
);

    localparam int AW = $clog2(MEM_BYTES);

    logic [7:0]                 mem [MEM_BYTES];
    mem_ctrl_pkg::cache_req_t   held;
    logic                       after_finish;   // first resting cycle after finished
    int                         wait_cnt;
    int                         seed;
    logic [AW-1:0]              ba;
    logic [`MC_WORD_W-1:0]      rd_word;

    function automatic logic [7:0] init_byte(input int a);
        return 8'(a * 7) ^ 8'(a >> 5);
    endfunction

    function automatic int size_bytes(input mem_ctrl_pkg::data_type_e dt);
        case (dt)
            mem_ctrl_pkg::DT_ONE_BYTE: return 1;
            mem_ctrl_pkg::DT_TWO_BYTE: return 2;
            default:                   return 4;
        endcase
    endfunction

    initial begin
        seed = 38;
        for (int a = 0; a < MEM_BYTES; a++) begin
            mem[a] = init_byte(a);
        end
    end

    always @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cache_status <= mem_ctrl_pkg::CACHE_RESTING;
            cache_rdata  <= '0;
            held         <= '0;
            after_finish <= 1'b0;
            wait_cnt     <= 0;
            access_count <= 0;
            proto_err    <= 1'b0;
        end else begin
            case (cache_status)
                mem_ctrl_pkg::CACHE_RESTING: begin
                    after_finish <= 1'b0;
                    if (cache_req.cmd != mem_ctrl_pkg::CACHE_NOP) begin
                        if (after_finish) proto_err <= 1'b1;   // no nop gap
                        held         <= cache_req;
                        wait_cnt     <= {$random(seed)} % 4;
                        access_count <= access_count + 1;
                        cache_status <= mem_ctrl_pkg::CACHE_BUSY;
                    end
                end
                mem_ctrl_pkg::CACHE_BUSY: begin
                    if (cache_req != held) proto_err <= 1'b1;
                    if (wait_cnt == 0) begin
                        rd_word = '0;
                        for (int b = 0; b < size_bytes(held.data_type); b++) begin
                            ba = AW'(held.addr) + AW'(b);
                            if (held.cmd == mem_ctrl_pkg::CACHE_STORE) begin
                                mem[ba] <= held.wdata[8*b +: 8];
                            end
                            rd_word[8*b +: 8] = mem[ba];
                        end
                        cache_rdata  <= rd_word;
                        cache_status <= mem_ctrl_pkg::CACHE_FINISHED;
                    end else begin
                        wait_cnt <= wait_cnt - 1;
                    end
                end
                default: begin
                    if (cache_req != held) proto_err <= 1'b1;
                    after_finish <= 1'b1;
                    cache_status <= mem_ctrl_pkg::CACHE_RESTING;
                end
            endcase
        end
    end

endmodule

// ==== design/mem_ctrl_top.sv ====
/*
 * Load/store controller top.
 * Core request in, one 32-bit data cache port out.
 * capture -> sequencer -> load assembler
 */
`timescale 1ns/1ps
`include "mem_ctrl_macros.svh"

module mem_ctrl_top (
    input  logic                            clk,
    input  logic                            arst_n,
    input  logic                            mem_access_enabled,
    input  mem_ctrl_pkg::mem_op_e           op,
    input  logic                            is_vector,
    input  mem_ctrl_pkg::data_type_e        data_type,
    input  logic [`MC_ADDR_W-1:0]           addr,
    input  logic [`MC_LEN_W-1:0]            length,
    input  logic                            vm,
    input  logic [`MC_MAX_ELEMS-1:0]        mask,
    input  logic [`MC_SCALAR_W-1:0]         scalar_wdata,
    input  logic [`MC_VEC_W-1:0]            vector_wdata,
    output mem_ctrl_pkg::mem_status_e       mem_status,
    output logic [`MC_SCALAR_W-1:0]         scalar_rdata,
    output logic [`MC_VEC_W-1:0]            vector_rdata,
    output mem_ctrl_pkg::cache_req_t        cache_req,
    input  mem_ctrl_pkg::cache_status_e     cache_status,
    input  logic [`MC_WORD_W-1:0]           cache_rdata
);

    mem_ctrl_pkg::mem_req_t     req;
    mem_ctrl_pkg::load_beat_t   beat;
    logic                       start;
    logic                       idle;

    mem_req_capture u_capture (
        .clk                (clk),
        .arst_n             (arst_n),
        .mem_access_enabled (mem_access_enabled),
        .op                 (op),
        .is_vector          (is_vector),
        .data_type          (data_type),
        .addr               (addr),
        .length             (length),
        .vm                 (vm),
        .mask               (mask),
        .scalar_wdata       (scalar_wdata),
        .vector_wdata       (vector_wdata),
        .idle               (idle),
        .req                (req),
        .start              (start)
    );

    mem_access_seq u_seq (
        .clk          (clk),
        .arst_n       (arst_n),
        .req          (req),
        .start        (start),
        .cache_status (cache_status),
        .cache_rdata  (cache_rdata),
        .cache_req    (cache_req),
        .beat         (beat),
        .mem_status   (mem_status),
        .idle         (idle)
    );

    mem_load_assemble u_assemble (
        .clk          (clk),
        .arst_n       (arst_n),
        .start        (start),
        .beat         (beat),
        .scalar_rdata (scalar_rdata),
        .vector_rdata (vector_rdata)
    );

endmodule

// ==== design/mem_load_assemble.sv ====
/*
 * Load result assembler.
 * Places returned cache words into the scalar or vector result.
 * Vector elements land at byte offset elem*size, four-byte scalars are
 * sign-extended, eight-byte scalars fill low then high half.
 */
`timescale 1ns/1ps
`include "mem_ctrl_macros.svh"

module mem_load_assemble (
    input  logic                            clk,
    input  logic                            arst_n,
    input  logic                            start,
    input  mem_ctrl_pkg::load_beat_t        beat,
    output logic [`MC_SCALAR_W-1:0]         scalar_rdata,
    output logic [`MC_VEC_W-1:0]            vector_rdata
);

    logic scalar_beat;
    logic vector_beat;

    assign scalar_beat = beat.valid && !beat.is_vector;
    assign vector_beat = beat.valid && beat.is_vector;

    // skipped elements stay zero from the clear
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            vector_rdata <= '0;
        end else if (start) begin
            vector_rdata <= '0;
        end else if (vector_beat) begin
            case (beat.data_type)
                mem_ctrl_pkg::DT_ONE_BYTE: begin
                    vector_rdata[8*beat.elem +: 8] <= beat.data[7:0];
                end
                mem_ctrl_pkg::DT_TWO_BYTE: begin
                    vector_rdata[16*beat.elem +: 16] <= beat.data[15:0];
                end
                default: begin
                    vector_rdata[32*beat.elem +: 32] <= beat.data;
                end
            endcase
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            scalar_rdata <= '0;
        end else if (scalar_beat) begin
            if (beat.data_type == mem_ctrl_pkg::DT_EIGHT_BYTE) begin
                if (beat.high) begin
                    scalar_rdata[`MC_SCALAR_W-1:`MC_WORD_W] <= beat.data;
                end else begin
                    scalar_rdata[`MC_WORD_W-1:0] <= beat.data;
                end
            end else begin
                scalar_rdata <= {{(`MC_SCALAR_W-`MC_WORD_W){beat.data[`MC_WORD_W-1]}},
                                 beat.data};
            end
        end
    end

endmodule

// ==== design/mem_access_seq.sv ====
/*
 * Access sequencer.
 * Walks the active slots of a latched request, one cache access at a
 * time, holding each command until the cache reports finished. Picks
 * the store word, advances address and element, and hands each returned
 * load word to the assembler as a one-cycle beat.
 */
`timescale 1ns/1ps
`include "mem_ctrl_macros.svh"

module mem_access_seq (
    input  logic                            clk,
    input  logic                            arst_n,
    input  mem_ctrl_pkg::mem_req_t          req,
    input  logic                            start,
    input  mem_ctrl_pkg::cache_status_e     cache_status,
    input  logic [`MC_WORD_W-1:0]           cache_rdata,
    output mem_ctrl_pkg::cache_req_t        cache_req,
    output mem_ctrl_pkg::load_beat_t        beat,
    output mem_ctrl_pkg::mem_status_e       mem_status,
    output logic                            idle
);

    localparam int IDX_W = $clog2(`MC_MAX_ELEMS);

    typedef enum logic [1:0] {
        S_IDLE,
        S_WAIT,     // cache must rest before the next slot
        S_HOLD,     // command held until finished
        S_DONE
    } state_e;

    state_e                         state;
    logic [IDX_W-1:0]               idx;
    logic [`MC_ADDR_W-1:0]          cur_addr;
    logic [`MC_MAX_ELEMS-1:0]       pending;
    logic [`MC_ADDR_W-1:0]          step;
    logic [`MC_WORD_W-1:0]          wdata_sel;
    mem_ctrl_pkg::data_type_e       acc_type;
    mem_ctrl_pkg::cache_cmd_e       cmd_sel;
    logic                           cache_done;

    // bit 0 of pending is the current slot
    assign pending    = req.active >> idx;
    assign cache_done = (state == S_HOLD) && (cache_status == mem_ctrl_pkg::CACHE_FINISHED);
    assign cmd_sel    = (req.op == mem_ctrl_pkg::MEM_STORE) ? mem_ctrl_pkg::CACHE_STORE
                                                            : mem_ctrl_pkg::CACHE_LOAD;

    // scalar halves go out as plain four-byte words
    always_comb begin
        step      = `MC_ADDR_W'(4);
        acc_type  = mem_ctrl_pkg::DT_FOUR_BYTE;
        wdata_sel = idx[0] ? req.scalar_wdata[`MC_SCALAR_W-1:`MC_WORD_W]
                           : req.scalar_wdata[`MC_WORD_W-1:0];
        if (req.is_vector) begin
            acc_type = req.data_type;
            case (req.data_type)
                mem_ctrl_pkg::DT_ONE_BYTE: begin
                    step      = `MC_ADDR_W'(1);
                    wdata_sel = `MC_WORD_W'(req.vector_wdata[8*idx +: 8]);
                end
                mem_ctrl_pkg::DT_TWO_BYTE: begin
                    step      = `MC_ADDR_W'(2);
                    wdata_sel = `MC_WORD_W'(req.vector_wdata[16*idx +: 16]);
                end
                default: begin
                    wdata_sel = req.vector_wdata[32*idx +: 32];
                end
            endcase
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state     <= S_IDLE;
            idx       <= '0;
            cur_addr  <= '0;
            cache_req <= '0;    // cmd nop
        end else begin
            case (state)
                S_IDLE: begin
                    if (start) begin
                        state    <= S_WAIT;
                        idx      <= '0;
                        cur_addr <= req.addr;
                    end
                end
                S_WAIT: begin
                    if (pending == '0) begin
                        state <= S_DONE;
                    end else if (!pending[0]) begin
                        // an inactive element still consumes its slot
                        idx      <= idx + 1'b1;
                        cur_addr <= cur_addr + step;
                    end else if (cache_status == mem_ctrl_pkg::CACHE_RESTING) begin
                        state     <= S_HOLD;
                        cache_req <= '{cmd: cmd_sel, addr: cur_addr, wdata: wdata_sel,
                                       data_type: acc_type};
                    end
                end
                S_HOLD: begin
                    if (cache_done) begin
                        cache_req.cmd <= mem_ctrl_pkg::CACHE_NOP;
                        idx           <= idx + 1'b1;
                        cur_addr      <= cur_addr + step;
                        // last access goes straight to done
                        state         <= (pending[`MC_MAX_ELEMS-1:1] == '0) ? S_DONE : S_WAIT;
                    end
                end
                S_DONE: begin
                    state <= S_IDLE;
                end
                default: begin
                    state <= S_IDLE;
                end
            endcase
        end
    end

    always_comb begin
        case (state)
            S_IDLE: begin
                mem_status = start ? mem_ctrl_pkg::MEM_WORKING : mem_ctrl_pkg::MEM_RESTING;
            end
            S_WAIT: begin
                if (pending[0] && cache_status != mem_ctrl_pkg::CACHE_RESTING) begin
                    mem_status = mem_ctrl_pkg::MEM_STALL;
                end else begin
                    mem_status = mem_ctrl_pkg::MEM_WORKING;
                end
            end
            S_HOLD:  mem_status = mem_ctrl_pkg::MEM_WORKING;
            default: mem_status = mem_ctrl_pkg::MEM_FINISHED;
        endcase
    end

    // blocks a second take while start is in flight
    assign idle = (state == S_IDLE) && !start;

    assign beat = '{valid: cache_done && (cache_req.cmd == mem_ctrl_pkg::CACHE_LOAD),
                    is_vector: req.is_vector,
                    data_type: req.data_type,
                    elem: idx,
                    high: !req.is_vector && idx[0],
                    data: cache_rdata};

endmodule

// ==== design/mem_req_capture.sv ====
/*
 * Request capture stage.
 * Latches one core request while the controller is idle and turns the
 * length, mask and vm (or the scalar size) into a set of active access
 * slots, then pulses start toward the sequencer.
 */
`timescale 1ns/1ps
`include "mem_ctrl_macros.svh"

module mem_req_capture (
    input  logic                            clk,
    input  logic                            arst_n,
    input  logic                            mem_access_enabled,
    input  mem_ctrl_pkg::mem_op_e           op,
    input  logic                            is_vector,
    input  mem_ctrl_pkg::data_type_e        data_type,
    input  logic [`MC_ADDR_W-1:0]           addr,
    input  logic [`MC_LEN_W-1:0]            length,
    input  logic                            vm,
    input  logic [`MC_MAX_ELEMS-1:0]        mask,
    input  logic [`MC_SCALAR_W-1:0]         scalar_wdata,
    input  logic [`MC_VEC_W-1:0]            vector_wdata,
    input  logic                            idle,
    output mem_ctrl_pkg::mem_req_t          req,
    output logic                            start
);

    logic                       take;
    logic [`MC_MAX_ELEMS-1:0]   active;

    assign take = mem_access_enabled && idle;

    always_comb begin
        active = '0;
        if (op != mem_ctrl_pkg::MEM_NOP) begin
            if (is_vector) begin
                for (int i = 0; i < `MC_MAX_ELEMS; i++) begin
                    active[i] = (`MC_LEN_W'(i) < length) && (mask[i] || vm);
                end
            end else begin
                active[0] = 1'b1;   // low word always
                active[1] = (data_type == mem_ctrl_pkg::DT_EIGHT_BYTE);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            req <= '{op: op, is_vector: is_vector, data_type: data_type, addr: addr,
                     length: length, active: active, scalar_wdata: scalar_wdata,
                     vector_wdata: vector_wdata};
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            start <= 1'b0;
        end else begin
            start <= take;
        end
    end

endmodule

// ==== design/mem_ctrl_pkg.sv ====
/*
 * Load/store controller types.
 * Enums for element size, core op, cache command and the two status
 * levels, plus the latched request, one cache access and one load beat.
 */
`include "mem_ctrl_macros.svh"

package mem_ctrl_pkg;

    typedef enum logic [2:0] {
        DT_ONE_BYTE   = 3'd0,
        DT_TWO_BYTE   = 3'd1,
        DT_FOUR_BYTE  = 3'd2,
        DT_EIGHT_BYTE = 3'd3    // scalar only
    } data_type_e;

    typedef enum logic [1:0] {
        MEM_NOP   = 2'd0,
        MEM_LOAD  = 2'd1,
        MEM_STORE = 2'd2
    } mem_op_e;

    typedef enum logic [1:0] {
        CACHE_NOP   = 2'd0,
        CACHE_LOAD  = 2'd1,
        CACHE_STORE = 2'd2
    } cache_cmd_e;

    typedef enum logic [1:0] {
        CACHE_RESTING  = 2'd0,
        CACHE_BUSY     = 2'd1,
        CACHE_FINISHED = 2'd2
    } cache_status_e;

    typedef enum logic [1:0] {
        MEM_RESTING  = 2'd0,
        MEM_WORKING  = 2'd1,
        MEM_STALL    = 2'd2,
        MEM_FINISHED = 2'd3
    } mem_status_e;

    typedef struct packed {
        mem_op_e                   op;
        logic                      is_vector;
        data_type_e                data_type;
        logic [`MC_ADDR_W-1:0]     addr;
        logic [`MC_LEN_W-1:0]      length;
        logic [`MC_MAX_ELEMS-1:0]  active;       // one bit per access slot
        logic [`MC_SCALAR_W-1:0]   scalar_wdata;
        logic [`MC_VEC_W-1:0]      vector_wdata;
    } mem_req_t;

    typedef struct packed {
        cache_cmd_e                cmd;
        logic [`MC_ADDR_W-1:0]     addr;
        logic [`MC_WORD_W-1:0]     wdata;
        data_type_e                data_type;
    } cache_req_t;

    typedef struct packed {
        logic                                valid;
        logic                                is_vector;
        data_type_e                          data_type;
        logic [$clog2(`MC_MAX_ELEMS)-1:0]    elem;
        logic                                high;   // upper scalar half
        logic [`MC_WORD_W-1:0]               data;
    } load_beat_t;

endpackage

// ==== design/mem_ctrl_macros.svh ====
/*
 * Load/store controller widths and limits.
 * Shared by the package and every RTL block.
 */
`ifndef MEM_CTRL_MACROS_SVH
`define MEM_CTRL_MACROS_SVH

// byte address into the data cache
`define MC_ADDR_W 20
// cache port data word
`define MC_WORD_W 32
// scalar register
`define MC_SCALAR_W 64

`define MC_MAX_ELEMS 8
// holds 0 to MC_MAX_ELEMS
`define MC_LEN_W 4
// vector register
`define MC_VEC_W 256

`endif
